/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire alu_op_e op,
    output word_t        result
);

    word_t sum;
    word_t diff;

    // adder shared by add, addi, auipc, jalr and address calc
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            alu_add: result = sum;
            alu_sub: result = diff;
            // compares land in bit 0, upper bits zero
            alu_sltu: result = word_t'(a < b);
            alu_xor: result = a ^ b;
            alu_or: result = a | b;
            // bne condition
            alu_ne: result = word_t'(a != b);
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire word_t inst,
    output ctrl_t      ctrl,
    output word_t      imm
);

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam word_t ebreak_inst  = 32'h0010_0073;

    opcode_e    opcode;
    funct3_e    funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = funct3_e'(inst[14:12]);
    assign funct7 = inst[31:25];

    // all immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // defaults: alu add, wb from alu, nothing enabled
        ctrl     = '0;
        ctrl.rd  = inst[11:7];
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        imm      = '0;
        case (opcode)
            op_lui: begin
                ctrl.reg_wen = 1'b1;
                ctrl.wb_src  = wb_imm;
                imm          = imm_u;
            end
            op_auipc: begin
                // pc + imm through the alu
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_wen     = 1'b1;
                imm              = imm_u;
            end
            op_jal: begin
                ctrl.is_jal  = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.wb_src  = wb_pc4;
                imm          = imm_j;
            end
            op_jalr: begin
                // alu forms rs1 + imm, core clears bit 0
                ctrl.is_jalr     = (funct3 == f3_add_byte);
                ctrl.reg_wen     = (funct3 == f3_add_byte);
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_src      = wb_pc4;
                ctrl.illegal     = (funct3 != f3_add_byte);
                imm              = imm_i;
            end
            op_branch: begin
                // only bne, taken when alu_ne returns 1
                ctrl.is_bne  = (funct3 == f3_bne);
                ctrl.alu_op  = alu_ne;
                ctrl.illegal = (funct3 != f3_bne);
                imm          = imm_b;
            end
            op_load: begin
                ctrl.mem_read    = (funct3 == f3_word) || (funct3 == f3_xor_lbu);
                ctrl.reg_wen     = ctrl.mem_read;
                ctrl.mem_byte    = (funct3 == f3_xor_lbu);
                ctrl.src2_is_imm = 1'b1;
                ctrl.wb_src      = wb_mem;
                ctrl.illegal     = !ctrl.mem_read;
                imm              = imm_i;
            end
            op_store: begin
                ctrl.mem_write   = (funct3 == f3_word) || (funct3 == f3_add_byte);
                ctrl.mem_byte    = (funct3 == f3_add_byte);
                ctrl.src2_is_imm = 1'b1;
                ctrl.illegal     = !ctrl.mem_write;
                imm              = imm_s;
            end
            op_imm: begin
                // addi and sltiu only
                ctrl.src2_is_imm = 1'b1;
                ctrl.alu_op      = (funct3 == f3_sltu) ? alu_sltu : alu_add;
                ctrl.reg_wen     = (funct3 == f3_add_byte) || (funct3 == f3_sltu);
                ctrl.illegal     = !ctrl.reg_wen;
                imm              = imm_i;
            end
            op_reg: begin
                ctrl.reg_wen = 1'b1;
                if (funct7 == f7_alt && funct3 == f3_add_byte) begin
                    ctrl.alu_op = alu_sub;
                end else if (funct7 == f7_base && funct3 == f3_add_byte) begin
                    ctrl.alu_op = alu_add;
                end else if (funct7 == f7_base && funct3 == f3_sltu) begin
                    ctrl.alu_op = alu_sltu;
                end else if (funct7 == f7_base && funct3 == f3_xor_lbu) begin
                    ctrl.alu_op = alu_xor;
                end else if (funct7 == f7_base && funct3 == f3_or) begin
                    ctrl.alu_op = alu_or;
                end else begin
                    ctrl.reg_wen = 1'b0;
                    ctrl.illegal = 1'b1;
                end
            end
            op_system: begin
                // exact ebreak word, ecall and csr ops fall to illegal
                ctrl.is_ebreak = (inst == ebreak_inst);
                ctrl.illegal   = (inst != ebreak_inst);
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/main_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module main_memory
    import rv_isa_pkg::*;
    `include "rv_config.svh"
(
    input  wire             clk,
    input  wire             load_we,
    input  wire addr_t      load_addr,
    input  wire word_t      load_data,
    input  wire addr_t      fetch_addr,
    output word_t           fetch_data,
    input  wire addr_t      dmem_addr,
    input  wire             dmem_we,
    input  wire [3:0]       dmem_mask,
    input  wire word_t      dmem_wdata,
    output word_t           dmem_rdata
);

    word_t    mem [0:`RV_MEM_WORDS-1];
    mem_idx_t load_idx;
    mem_idx_t fetch_idx;
    mem_idx_t dmem_idx;

    // byte address to word index
    // offset from base, drop byte bits, wrap at depth
    function automatic mem_idx_t to_idx(addr_t addr);
        addr_t offset;
        offset = addr - addr_t'(`RV_RESET_PC);
        return mem_idx_t'(offset >> 2);
    endfunction

    assign load_idx  = to_idx(load_addr);
    assign fetch_idx = to_idx(fetch_addr);
    assign dmem_idx  = to_idx(dmem_addr);

    // two combinational read ports
    assign fetch_data = mem[fetch_idx];
    assign dmem_rdata = mem[dmem_idx];

    // program load wins over a core store in the same cycle
    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_idx] <= load_data;
        end else if (dmem_we) begin
            for (int i = 0; i < 4; i++) begin
                // byte lane write
                if (dmem_mask[i]) begin
                    mem[dmem_idx][8*i +: 8] <= dmem_wdata[8*i +: 8];
                end
            end
        end
    end

    // pc arrives from the core, never on a half-word
    a_fetch_aligned: assert property (
        @(posedge clk) !$isunknown(fetch_addr) |-> fetch_addr[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* hdl/npc_core.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_core
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
    `include "rv_config.svh"
(
    input  wire         clk,
    input  wire         reset,
    output addr_t       fetch_addr,
    input  wire word_t  fetch_data,
    output addr_t       dmem_addr,
    output logic        dmem_we,
    output logic [3:0]  dmem_mask,
    output word_t       dmem_wdata,
    input  wire word_t  dmem_rdata,
    output logic        retire_valid,
    output retire_t     retire,
    output logic        halted
);

    addr_t      pc;
    addr_t      pc_next;
    addr_t      pc_plus4;
    addr_t      pc_target;
    ctrl_t      ctrl;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    word_t      load_data;
    word_t      wb_data;
    logic [1:0] byte_off;
    logic       active;
    logic       stop;
    logic       branch_taken;
    logic       reg_wen;

    assign fetch_addr = pc;

    inst_decoder u_decoder (
        .inst (fetch_data),
        .ctrl (ctrl),
        .imm  (imm)
    );

    register_file u_regfile (
        .clk    (clk),
        .wen    (reg_wen),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // operand select, pc for auipc, imm for I/S types
    assign alu_a = ctrl.src1_is_pc ? pc : rs1_data;
    assign alu_b = ctrl.src2_is_imm ? imm : rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // no side effects in reset or after halt
    assign active       = !reset && !halted;
    assign stop         = ctrl.is_ebreak || ctrl.illegal;
    assign retire_valid = active;

    // next pc
    assign pc_plus4     = pc + addr_t'(4);
    assign pc_target    = pc + imm;
    assign branch_taken = ctrl.is_bne && alu_result[0];

    always_comb begin
        if (ctrl.is_jalr) begin
            pc_next = {alu_result[31:1], 1'b0};
        end else if (ctrl.is_jal || branch_taken) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // pc holds on the halting instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (stop) begin
                halted <= 1'b1;
            end else begin
                pc <= pc_next;
            end
        end
    end

    // data port, address from rs1 + imm
    assign dmem_addr = alu_result;
    assign byte_off  = alu_result[1:0];
    assign dmem_we   = active && ctrl.mem_write;

    // sb moves rs2[7:0] into the addressed lane
    assign dmem_mask  = ctrl.mem_byte ? (4'b0001 << byte_off) : 4'b1111;
    assign dmem_wdata = ctrl.mem_byte ? (rs2_data << {byte_off, 3'b000}) : rs2_data;

    // lbu picks one lane, zero extended
    assign load_data = ctrl.mem_byte ? word_t'(dmem_rdata[{byte_off, 3'b000} +: 8])
                                     : dmem_rdata;

    always_comb begin
        case (ctrl.wb_src)
            wb_alu: wb_data = alu_result;
            wb_mem: wb_data = load_data;
            wb_pc4: wb_data = pc_plus4;
            wb_imm: wb_data = imm;
            default: wb_data = alu_result;
        endcase
    end

    assign reg_wen = active && ctrl.reg_wen;

    // retire record, writes to x0 reported as no writeback
    assign retire.pc      = pc;
    assign retire.wb_en   = reg_wen && (ctrl.rd != '0);
    assign retire.wb_rd   = ctrl.rd;
    assign retire.wb_data = wb_data;
    assign retire.st_en   = dmem_we;
    assign retire.st_addr = dmem_addr;
    assign retire.st_data = dmem_wdata;
    assign retire.st_mask = dmem_mask;

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    );

    // the halting word never stores, nor does anything after it
    a_halt_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (stop || halted) |-> !dmem_we
    );

endmodule

`default_nettype wire

/* hdl/npc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_top import rv_isa_pkg::*, rv_ctrl_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        load_we,
    input  wire addr_t load_addr,
    input  wire word_t load_data,
    output logic       retire_valid,
    output retire_t    retire,
    output logic       halted
);

    // core to memory
    wire addr_t      fetch_addr;
    wire word_t      fetch_data;
    wire addr_t      dmem_addr;
    wire             dmem_we;
    wire logic [3:0] dmem_mask;
    wire word_t      dmem_wdata;
    wire word_t      dmem_rdata;

    npc_core u_core (
        .clk          (clk),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .dmem_addr    (dmem_addr),
        .dmem_we      (dmem_we),
        .dmem_mask    (dmem_mask),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    // load port goes straight to memory, usable during reset
    main_memory u_mem (
        .clk        (clk),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_mask  (dmem_mask),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file
    import rv_isa_pkg::*;
    `include "rv_config.svh"
(
    input  wire           clk,
    input  wire           wen,
    input  wire reg_idx_t waddr,
    input  wire word_t    wdata,
    input  wire reg_idx_t raddr1,
    input  wire reg_idx_t raddr2,
    output word_t         rdata1,
    output word_t         rdata2
);

    // x0 has no storage
    word_t regs [1:`RV_NREGS-1];

    // write at the edge, visible to reads next cycle
    always_ff @(posedge clk) begin
        if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // core must not enable a write with a floating rd
    a_wen_addr_known: assert property (
        @(posedge clk) wen |-> !$isunknown(waddr)
    );

endmodule

`default_nettype wire

/* hdl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// unified memory depth in 32-bit words
// keep a power of two, the index wraps
`define RV_MEM_WORDS 4096

// datapath width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_NREGS 32

`endif

/* hdl/rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

    import rv_isa_pkg::*;

    // alu function select
    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_sub  = 3'd1,
        alu_sltu = 3'd2,
        alu_xor  = 3'd3,
        alu_or   = 3'd4,
        alu_ne   = 3'd5
    } alu_op_e;

    // register writeback source
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2,
        wb_imm = 2'd3
    } wb_src_e;

    // decoded control for one instruction
    typedef struct packed {
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     reg_wen;
        wb_src_e  wb_src;
        logic     mem_read;
        logic     mem_write;
        // lbu / sb
        logic     mem_byte;
        logic     is_jal;
        logic     is_jalr;
        logic     is_bne;
        logic     is_ebreak;
        logic     illegal;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } ctrl_t;

    // per-instruction retire record
    typedef struct packed {
        addr_t      pc;
        logic       wb_en;
        reg_idx_t   wb_rd;
        word_t      wb_data;
        logic       st_en;
        addr_t      st_addr;
        word_t      st_data;
        logic [3:0] st_mask;
    } retire_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    `include "rv_config.svh"

    // data and instruction word
    typedef logic [`RV_XLEN-1:0] word_t;

    // byte address
    typedef logic [`RV_XLEN-1:0] addr_t;

    // register index, x0..x31
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // word index into main memory
    typedef logic [$clog2(`RV_MEM_WORDS)-1:0] mem_idx_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    // funct3, inst[14:12]
    // one value covers several classes, meaning depends on opcode
    typedef enum logic [2:0] {
        f3_add_byte = 3'b000,
        f3_bne      = 3'b001,
        f3_word     = 3'b010,
        f3_sltu     = 3'b011,
        f3_xor_lbu  = 3'b100,
        f3_or       = 3'b110
    } funct3_e;

endpackage

`default_nettype wire

/* npc_top.f */
+incdir+hdl
+incdir+verif
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/inst_decoder.sv
hdl/alu.sv
hdl/register_file.sv
hdl/main_memory.sv
hdl/npc_core.sv
hdl/npc_top.sv
verif/npc_tb.sv

/* verif/npc_ref_model.svh */
`ifndef NPC_REF_MODEL_SVH
`define NPC_REF_MODEL_SVH

// program shape: 32 prologue words, random body, ebreak last
localparam int prog_words = 81;
localparam int data_words = 256;
// seeded data window, x1 +/- 512 bytes
localparam word_t data_lo = `RV_RESET_PC + 32'h2000 - 32'h200;

// instruction kinds, body draws 0..15
localparam int k_lui = 0;
localparam int k_auipc = 1;
localparam int k_jal = 2;
localparam int k_jalr = 3;
localparam int k_addi = 4;
localparam int k_sltiu = 5;
localparam int k_add = 6;
localparam int k_sub = 7;
localparam int k_xor = 8;
localparam int k_or = 9;
localparam int k_sltu = 10;
localparam int k_lw = 11;
localparam int k_lbu = 12;
localparam int k_sw = 13;
localparam int k_sb = 14;
localparam int k_bne = 15;
localparam int k_ebreak = 16;

// generated program, one entry per word
int    g_kind [0:prog_words-1];
int    g_rd   [0:prog_words-1];
int    g_rs1  [0:prog_words-1];
int    g_rs2  [0:prog_words-1];
word_t g_imm  [0:prog_words-1];
word_t prog   [0:prog_words-1];
// word is the landing spot of some earlier jump
bit    g_target [0:prog_words-1];

// architectural state of the model
word_t m_pc;
word_t m_regs [0:31];
word_t m_mem  [0:`RV_MEM_WORDS-1];

// byte address to word slot, wraps at memory depth
function automatic int mem_index(input word_t addr);
    return int'(((addr - `RV_RESET_PC) >> 2) % `RV_MEM_WORDS);
endfunction

function automatic word_t rand_imm12();
    return word_t'(int'($urandom % 4096) - 2048);
endfunction

// any rd but x1, x0 included
function automatic int pick_rd();
    int rd;
    rd = int'($urandom % 31);
    if (rd != 0) begin
        rd = rd + 1;
    end
    return rd;
endfunction

// rv32i field layout
function automatic word_t encode_inst(input int kind, input int rd, input int rs1,
                                      input int rs2, input word_t imm);
    logic [4:0] d;
    logic [4:0] s1;
    logic [4:0] s2;
    d  = 5'(rd);
    s1 = 5'(rs1);
    s2 = 5'(rs2);
    case (kind)
        k_lui:   return {imm[31:12], d, 7'h37};
        k_auipc: return {imm[31:12], d, 7'h17};
        k_jal:   return {imm[20], imm[10:1], imm[11], imm[19:12], d, 7'h6f};
        k_jalr:  return {imm[11:0], s1, 3'h0, d, 7'h67};
        k_addi:  return {imm[11:0], s1, 3'h0, d, 7'h13};
        k_sltiu: return {imm[11:0], s1, 3'h3, d, 7'h13};
        k_add:   return {7'h00, s2, s1, 3'h0, d, 7'h33};
        k_sub:   return {7'h20, s2, s1, 3'h0, d, 7'h33};
        k_xor:   return {7'h00, s2, s1, 3'h4, d, 7'h33};
        k_or:    return {7'h00, s2, s1, 3'h6, d, 7'h33};
        k_sltu:  return {7'h00, s2, s1, 3'h3, d, 7'h33};
        k_lw:    return {imm[11:0], s1, 3'h2, d, 7'h03};
        k_lbu:   return {imm[11:0], s1, 3'h4, d, 7'h03};
        k_sw:    return {imm[11:5], s2, s1, 3'h2, imm[4:0], 7'h23};
        k_sb:    return {imm[11:5], s2, s1, 3'h0, imm[4:0], 7'h23};
        k_bne:   return {imm[12], imm[10:5], s2, s1, 3'h1, imm[4:1], imm[11], 7'h63};
        default: return 32'h0010_0073;
    endcase
endfunction

task automatic place_inst(input int idx, input int kind, input int rd, input int rs1,
                          input int rs2, input word_t imm);
    g_kind[idx] = kind;
    g_rd[idx]   = rd;
    g_rs1[idx]  = rs1;
    g_rs2[idx]  = rs2;
    g_imm[idx]  = imm;
    prog[idx]   = encode_inst(kind, rd, rs1, rs2, imm);
    m_mem[mem_index(`RV_RESET_PC + 4 * idx)] = prog[idx];
endtask

task automatic gen_program();
    int i;
    int kind;
    int rd;
    int rs1;
    int rs2;
    int room;
    int skip;
    int base_reg;
    m_pc = `RV_RESET_PC;
    foreach (m_regs[r]) begin
        m_regs[r] = '0;
    end
    foreach (g_target[t]) begin
        g_target[t] = 1'b0;
    end
    for (int w = 0; w < data_words; w++) begin
        m_mem[mem_index(data_lo + 4 * w)] = $urandom;
    end
    // x1 = data area base, then every other register gets a value
    place_inst(0, k_lui, 1, 0, 0, `RV_RESET_PC + 32'h2000);
    place_inst(1, k_addi, 1, 1, 0, '0);
    for (int r = 2; r < 32; r++) begin
        place_inst(r, k_addi, r, 0, 0, rand_imm12());
    end
    i = 32;
    while (i < prog_words - 1) begin
        kind = int'($urandom % 16);
        rd   = pick_rd();
        rs1  = int'($urandom % 32);
        rs2  = int'($urandom % 32);
        // words left before the ebreak
        room = prog_words - 1 - i;
        skip = 1 + int'($urandom % ((room < 4) ? room : 4));
        case (kind)
            k_lui, k_auipc: place_inst(i, kind, rd, 0, 0, $urandom & 32'hffff_f000);
            k_jal: begin
                g_target[i + skip] = 1'b1;
                place_inst(i, kind, rd, 0, 0, word_t'(4 * skip));
            end
            k_jalr: begin
                // a jump landing on the jalr would skip its auipc
                if (room >= 2 && !g_target[i + 1]) begin
                    // auipc + jalr pair, target past the jalr
                    skip     = 1 + int'($urandom % ((room - 1 < 4) ? room - 1 : 4));
                    base_reg = 2 + int'($urandom % 30);
                    place_inst(i, k_auipc, base_reg, 0, 0, '0);
                    i++;
                    g_target[i + skip] = 1'b1;
                    // odd offset now and then, bit 0 must drop
                    place_inst(i, k_jalr, rd, base_reg, 0,
                               word_t'(4 * (1 + skip) + int'($urandom % 2)));
                end else begin
                    place_inst(i, k_addi, rd, rs1, 0, rand_imm12());
                end
            end
            k_lw, k_sw: place_inst(i, kind, rd, 1, rs2,
                                   word_t'(4 * (int'($urandom % 256) - 128)));
            k_lbu, k_sb: place_inst(i, kind, rd, 1, rs2,
                                    word_t'(int'($urandom % 1024) - 512));
            // equal operands a quarter of the time
            k_bne: begin
                g_target[i + skip] = 1'b1;
                place_inst(i, kind, 0, rs1, ($urandom % 4 == 0) ? rs1 : rs2,
                           word_t'(4 * skip));
            end
            default: place_inst(i, kind, rd, rs1, rs2, rand_imm12());
        endcase
        i++;
    end
    place_inst(prog_words - 1, k_ebreak, 0, 0, 0, '0);
endtask

// execute one instruction, return what should retire
task automatic model_step(output retire_t exp, output logic halt);
    int    idx;
    int    lane;
    word_t a;
    word_t b;
    word_t v;
    word_t addr;
    word_t npc;
    logic  wr;
    idx  = mem_index(m_pc);
    a    = m_regs[g_rs1[idx]];
    b    = m_regs[g_rs2[idx]];
    addr = a + g_imm[idx];
    lane = int'(addr[1:0]);
    npc  = m_pc + 4;
    v    = '0;
    wr   = 1'b1;
    halt = 1'b0;
    exp  = '0;
    exp.pc = m_pc;
    case (g_kind[idx])
        k_lui:   v = g_imm[idx];
        k_auipc: v = m_pc + g_imm[idx];
        k_jal: begin
            v   = m_pc + 4;
            npc = m_pc + g_imm[idx];
        end
        k_jalr: begin
            v   = m_pc + 4;
            npc = addr & ~32'h1;
        end
        k_addi:  v = addr;
        k_sltiu: v = (a < g_imm[idx]) ? 32'd1 : 32'd0;
        k_add:   v = a + b;
        k_sub:   v = a - b;
        k_xor:   v = a ^ b;
        k_or:    v = a | b;
        k_sltu:  v = (a < b) ? 32'd1 : 32'd0;
        k_lw:    v = m_mem[mem_index(addr)];
        k_lbu:   v = (m_mem[mem_index(addr)] >> (8 * lane)) & 32'hff;
        k_sw: begin
            wr          = 1'b0;
            exp.st_en   = 1'b1;
            exp.st_mask = 4'hf;
            exp.st_data = b;
        end
        k_sb: begin
            wr          = 1'b0;
            exp.st_en   = 1'b1;
            exp.st_mask = 4'b0001 << lane;
            exp.st_data = b << (8 * lane);
        end
        k_bne: begin
            wr = 1'b0;
            if (a != b) begin
                npc = m_pc + g_imm[idx];
            end
        end
        default: begin
            // ebreak, nothing written, pc stays
            wr   = 1'b0;
            halt = 1'b1;
        end
    endcase
    if (exp.st_en) begin
        exp.st_addr = addr;
        for (int k = 0; k < 4; k++) begin
            if (exp.st_mask[k]) begin
                m_mem[mem_index(addr)][8 * k +: 8] = exp.st_data[8 * k +: 8];
            end
        end
    end
    exp.wb_en   = wr && (g_rd[idx] != 0);
    exp.wb_rd   = reg_idx_t'(g_rd[idx]);
    exp.wb_data = v;
    if (exp.wb_en) begin
        m_regs[g_rd[idx]] = v;
    end
    if (!halt) begin
        m_pc = npc;
    end
endtask

`endif

/* verif/npc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module npc_tb import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

    `include "rv_config.svh"
    `include "npc_ref_model.svh"

    localparam int num_progs    = 20;
    localparam int reset_cycles = 10;
    localparam int clk_period   = 40;
    // load length plus four cycles per program word, per program
    localparam int timeout_cycles =
        num_progs * (prog_words + data_words + 4 * prog_words);

    logic    clk;
    logic    reset;
    logic    load_we;
    addr_t   load_addr;
    word_t   load_data;
    logic    retire_valid;
    retire_t retire;
    logic    halted;
    int      errors = 0;

    npc_top DUT (
        .clk          (clk),
        .reset        (reset),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .halted       (halted)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // byte mask to a 32-bit lane mask
    function automatic word_t lane_bits(input logic [3:0] mask);
        word_t bits;
        for (int k = 0; k < 4; k++) begin
            bits[8 * k +: 8] = {8{mask[k]}};
        end
        return bits;
    endfunction

    // program then data seeds through the load port, core held in reset
    task automatic load_and_reset();
        int    cycles;
        addr_t addr;
        cycles = 0;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < prog_words + data_words; i++) begin
            if (i < prog_words) begin
                addr = `RV_RESET_PC + 4 * i;
            end else begin
                addr = data_lo + 4 * (i - prog_words);
            end
            load_we   <= 1'b1;
            load_addr <= addr;
            load_data <= m_mem[mem_index(addr)];
            @(posedge clk);
            cycles++;
        end
        load_we <= 1'b0;
        while (cycles < reset_cycles) begin
            @(posedge clk);
            cycles++;
        end
        reset <= 1'b0;
    endtask

    // one model step per retire, sampled mid-cycle
    task automatic run_program();
        retire_t exp;
        logic    done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_value("retire_valid", 32'd1, word_t'(retire_valid));
            check_value("halted", 32'd0, word_t'(halted));
            model_step(exp, done);
            check_value("retire.pc", exp.pc, retire.pc);
            check_value("retire.wb_en", word_t'(exp.wb_en), word_t'(retire.wb_en));
            if (exp.wb_en) begin
                check_value("retire.wb_rd", word_t'(exp.wb_rd), word_t'(retire.wb_rd));
                check_value("retire.wb_data", exp.wb_data, retire.wb_data);
            end
            check_value("retire.st_en", word_t'(exp.st_en), word_t'(retire.st_en));
            if (exp.st_en) begin
                check_value("retire.st_addr", exp.st_addr, retire.st_addr);
                check_value("retire.st_mask", word_t'(exp.st_mask), word_t'(retire.st_mask));
                // only the written lanes carry meaning
                check_value("retire.st_data", exp.st_data & lane_bits(exp.st_mask),
                            retire.st_data & lane_bits(exp.st_mask));
            end
        end
        // halted core stays quiet
        repeat (8) begin
            @(negedge clk);
            check_value("halted", 32'd1, word_t'(halted));
            check_value("retire_valid", 32'd0, word_t'(retire_valid));
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(84416));
        for (int p = 0; p < num_progs; p++) begin
            gen_program();
            load_and_reset();
            run_program();
        end
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("watchdog expired, a program did not reach its ebreak in time");
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
